//--- include/ipc_defs.svh
// widths, counts and port numbers of the input port controller, included by every design file
`ifndef IPC_DEFS_SVH
`define IPC_DEFS_SVH

// virtual channels and buffer partitions
`define IPC_NUM_VCS 2
`define IPC_VC_IDX_WIDTH 1
`define IPC_VC_DEPTH 4
`define IPC_CNT_WIDTH 3

// router ports, node first, then x-, x+, y-, y+
`define IPC_NUM_PORTS 5
`define IPC_PORT_IDX_WIDTH 3
`define IPC_PORT_NODE 3'd0
`define IPC_PORT_XM 3'd1
`define IPC_PORT_XP 3'd2
`define IPC_PORT_YM 3'd3
`define IPC_PORT_YP 3'd4

// addressing in the 4x4 mesh, y in the upper half
`define IPC_DIM_ADDR_WIDTH 2
`define IPC_ROUTER_ADDR_WIDTH 4

// channel is valid, vc index, head, tail, data
`define IPC_FLIT_DATA_WIDTH 32
`define IPC_CHANNEL_WIDTH 36
`define IPC_FLOW_CTRL_WIDTH 2

`endif

//--- source/ipc_pkg.sv
// flit word types shared by the interfaces, the VC controllers and the lookahead update
`default_nettype none

`include "ipc_defs.svh"

package ipc_pkg;

   // ------------------------------
   // head flit layout
   // ------------------------------

   // lar_port is the output port at the router that holds the flit
   typedef struct packed {
      logic [`IPC_PORT_IDX_WIDTH-1:0] lar_port;
      logic [`IPC_DIM_ADDR_WIDTH-1:0] dest_y;
      logic [`IPC_DIM_ADDR_WIDTH-1:0] dest_x;
      logic [`IPC_FLIT_DATA_WIDTH-`IPC_PORT_IDX_WIDTH-2*`IPC_DIM_ADDR_WIDTH-1:0] payload;
   } flit_header_t;

   // body flits are read raw, head flits through hdr
   typedef union packed {
      logic [0:`IPC_FLIT_DATA_WIDTH-1] raw;
      flit_header_t                    hdr;
   } flit_word_u;

endpackage

`default_nettype wire

//--- source/ipc_push_if.sv
// staged incoming flit strobe from the channel input to the flit buffer and VC controllers
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

interface ipc_push_if
   import ipc_pkg::*;
();

   // a flit is present in every cycle with valid high
   logic                     valid;
   logic                     head;
   logic                     tail;
   logic [0:`IPC_NUM_VCS-1]  sel_ivc;
   flit_word_u               data;

   modport source (output valid, head, tail, sel_ivc, data);
   modport sink (input valid, head, tail, sel_ivc, data);

endinterface

`default_nettype wire

//--- source/ipc_front_if.sv
// per-VC buffer front state and pop strobes, driven by the flit buffer for its readers
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

interface ipc_front_if
   import ipc_pkg::*;
();

   logic [0:`IPC_NUM_VCS-1]       empty_ivc;
   // exactly one flit held
   logic [0:`IPC_NUM_VCS-1]       almost_empty_ivc;
   logic [0:`IPC_NUM_VCS-1]       tail_ivc;
   flit_word_u [0:`IPC_NUM_VCS-1] front_ivc;
   // high in the cycle a flit of that VC is removed
   logic [0:`IPC_NUM_VCS-1]       pop_ivc;

   modport buffer (output empty_ivc, almost_empty_ivc, tail_ivc, front_ivc, pop_ivc);
   modport reader (input empty_ivc, almost_empty_ivc, tail_ivc, front_ivc, pop_ivc);

endinterface

`default_nettype wire

//--- source/ipc_channel_input.sv
// channel input stage, registers the incoming channel and decodes its VC index to one-hot
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_channel_input (
   input  wire                          clk,
   input  wire                          reset,
   input  wire [0:`IPC_CHANNEL_WIDTH-1] channel_in,
   ipc_push_if.source                   push
);

   // field positions after the valid bit
   localparam int head_pos = 1 + `IPC_VC_IDX_WIDTH;
   localparam int tail_pos = head_pos + 1;
   localparam int data_pos = tail_pos + 1;

   logic                            valid_q;
   logic                            head_q;
   logic                            tail_q;
   logic [0:`IPC_VC_IDX_WIDTH-1]    vc_q;
   logic [0:`IPC_FLIT_DATA_WIDTH-1] data_q;

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= 1'b0;
      else
         valid_q <= channel_in[0];
   end

   // flit fields only matter while valid is set
   always_ff @(posedge clk)
   begin
      vc_q   <= channel_in[1 +: `IPC_VC_IDX_WIDTH];
      head_q <= channel_in[head_pos];
      tail_q <= channel_in[tail_pos];
      data_q <= channel_in[data_pos +: `IPC_FLIT_DATA_WIDTH];
   end

   always_comb
   begin
      push.sel_ivc       = '0;
      push.sel_ivc[vc_q] = 1'b1;
   end

   assign push.valid = valid_q;
   assign push.head  = head_q;
   assign push.tail  = tail_q;
   assign push.data  = data_q;

   a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
      push.valid |-> $onehot(push.sel_ivc));

endmodule

`default_nettype wire

//--- source/ipc_flit_buffer.sv
// statically partitioned flit buffer, one circular FIFO per VC with front peek and pop strobes
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_flit_buffer (
   input  wire                    clk,
   input  wire                    reset,
   ipc_push_if.sink               push,
   input  wire                    flit_sent_in,
   input  wire [0:`IPC_NUM_VCS-1] flit_sel_in_ivc,
   ipc_front_if.buffer            front,
   output logic [0:`IPC_NUM_VCS-1] overflow_ivc,
   output logic [0:`IPC_NUM_VCS-1] underflow_ivc
);

   localparam int ptr_width = $clog2(`IPC_VC_DEPTH);
   localparam logic [`IPC_CNT_WIDTH-1:0] depth_cnt = `IPC_CNT_WIDTH'(`IPC_VC_DEPTH);
   localparam logic [`IPC_CNT_WIDTH-1:0] cnt_one = `IPC_CNT_WIDTH'(1);
   localparam logic [ptr_width-1:0] ptr_one = ptr_width'(1);

   // ------------------------------
   // storage and pointers
   // ------------------------------

   logic [0:`IPC_FLIT_DATA_WIDTH-1] mem_q [0:`IPC_NUM_VCS-1][0:`IPC_VC_DEPTH-1];
   logic [0:`IPC_VC_DEPTH-1]        tail_mem_q [0:`IPC_NUM_VCS-1];
   logic [ptr_width-1:0]            wr_ptr_q [0:`IPC_NUM_VCS-1];
   logic [ptr_width-1:0]            rd_ptr_q [0:`IPC_NUM_VCS-1];
   logic [`IPC_CNT_WIDTH-1:0]       count_q [0:`IPC_NUM_VCS-1];

   logic [0:`IPC_NUM_VCS-1] push_req;
   logic [0:`IPC_NUM_VCS-1] pop_req;
   logic [0:`IPC_NUM_VCS-1] empty;
   logic [0:`IPC_NUM_VCS-1] full;
   logic [0:`IPC_NUM_VCS-1] wr_en;
   logic [0:`IPC_NUM_VCS-1] pop_en;

   assign push_req = push.sel_ivc & {`IPC_NUM_VCS{push.valid}};
   assign pop_req  = flit_sel_in_ivc & {`IPC_NUM_VCS{flit_sent_in}};

   // a push into a full partition is dropped, a send from an empty one ignored
   assign wr_en         = push_req & ~full;
   assign pop_en        = pop_req & ~empty;
   assign overflow_ivc  = push_req & full;
   assign underflow_ivc = pop_req & empty;

   always_ff @(posedge clk)
   begin
      for (int v = 0; v < `IPC_NUM_VCS; v++)
      begin
         if (wr_en[v])
         begin
            mem_q[v][wr_ptr_q[v]]      <= push.data;
            tail_mem_q[v][wr_ptr_q[v]] <= push.tail;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int v = 0; v < `IPC_NUM_VCS; v++)
      begin
         if (reset)
         begin
            wr_ptr_q[v] <= '0;
            rd_ptr_q[v] <= '0;
            count_q[v]  <= '0;
         end
         else
         begin
            if (wr_en[v])
               wr_ptr_q[v] <= wr_ptr_q[v] + ptr_one;
            if (pop_en[v])
               rd_ptr_q[v] <= rd_ptr_q[v] + ptr_one;
            case ({wr_en[v], pop_en[v]})
               2'b10:   count_q[v] <= count_q[v] + cnt_one;
               2'b01:   count_q[v] <= count_q[v] - cnt_one;
               default: count_q[v] <= count_q[v];
            endcase
         end
      end
   end

   // ------------------------------
   // front peek
   // ------------------------------

   always_comb
   begin
      for (int v = 0; v < `IPC_NUM_VCS; v++)
      begin
         empty[v]                 = (count_q[v] == '0);
         full[v]                  = (count_q[v] == depth_cnt);
         front.almost_empty_ivc[v] = (count_q[v] == cnt_one);
         front.tail_ivc[v]        = tail_mem_q[v][rd_ptr_q[v]];
         front.front_ivc[v]       = mem_q[v][rd_ptr_q[v]];
      end
   end

   assign front.empty_ivc = empty;
   assign front.pop_ivc   = pop_en;

   for (genvar v = 0; v < `IPC_NUM_VCS; v++)
   begin : g_chk
      a_count_bound: assert property (@(posedge clk) disable iff (reset)
         count_q[v] <= depth_cnt);
   end

endmodule

`default_nettype wire

//--- source/ipc_vc_ctrl.sv
// input VC controller, tracks head flits and the packet route and checks flit types for one VC
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_vc_ctrl
   import ipc_pkg::*;
#(
   parameter int vc_id = 0
) (
   input  wire                      clk,
   input  wire                      reset,
   ipc_push_if.sink                 push,
   ipc_front_if.reader              front,
   output logic                     flit_valid_out,
   output logic                     flit_last_out,
   output logic                     flit_head_out,
   output logic                     flit_tail_out,
   output logic [0:`IPC_NUM_PORTS-1] route_out_op,
   output logic                     error_flit_type,
   output logic                     error_invalid_port
);

   flit_word_u                     front_word;
   logic                           empty;
   logic                           pop;
   logic                           head_q;
   logic                           open_q;
   logic                           push_sel;
   logic [`IPC_PORT_IDX_WIDTH-1:0] route_q;
   logic [`IPC_PORT_IDX_WIDTH-1:0] sel_port;

   assign front_word = front.front_ivc[vc_id];
   assign empty      = front.empty_ivc[vc_id];
   assign pop        = front.pop_ivc[vc_id];
   assign push_sel   = push.valid & push.sel_ivc[vc_id];

   // ------------------------------
   // head tracking and route hold
   // ------------------------------

   // the flit after a tail starts the next packet
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         head_q  <= 1'b1;
         route_q <= `IPC_PORT_NODE;
      end
      else if (pop)
      begin
         head_q <= front.tail_ivc[vc_id];
         if (head_q)
            route_q <= front_word.hdr.lar_port;
      end
   end

   assign flit_valid_out = ~empty;
   assign flit_last_out  = front.almost_empty_ivc[vc_id];
   assign flit_head_out  = head_q;
   assign flit_tail_out  = front.tail_ivc[vc_id];

   // body flits follow the port captured from their head
   assign sel_port = head_q ? front_word.hdr.lar_port : route_q;

   always_comb
   begin
      route_out_op = '0;
      if (!empty && sel_port < `IPC_NUM_PORTS)
         route_out_op[sel_port] = 1'b1;
   end

   assign error_invalid_port = ~empty & head_q & (front_word.hdr.lar_port >= `IPC_NUM_PORTS);

   // ------------------------------
   // packet framing on the channel
   // ------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
         open_q <= 1'b0;
      else if (push_sel)
         open_q <= push.head ? ~push.tail : (open_q & ~push.tail);
   end

   assign error_flit_type = push_sel & (push.head ? open_q : ~open_q);

   a_route_onehot0: assert property (@(posedge clk) disable iff (reset)
      $onehot0(route_out_op));

endmodule

`default_nettype wire

//--- source/ipc_lookahead_update.sv
// output register that recomputes the lookahead port of sent head flits for the next router
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_lookahead_update
   import ipc_pkg::*;
(
   input  wire                              clk,
   input  wire                              reset,
   input  wire [0:`IPC_ROUTER_ADDR_WIDTH-1] router_address,
   ipc_front_if.reader                      front,
   input  wire [0:`IPC_NUM_VCS-1]           flit_head_ivc,
   output logic [0:`IPC_FLIT_DATA_WIDTH-1]  flit_data_out
);

   flit_word_u                     pop_word;
   flit_word_u                     out_word;
   logic                           pop_head;
   logic [`IPC_DIM_ADDR_WIDTH-1:0] next_x;
   logic [`IPC_DIM_ADDR_WIDTH-1:0] next_y;
   logic [`IPC_PORT_IDX_WIDTH-1:0] next_port;

   // popped word, pop_ivc is at most one-hot
   always_comb
   begin
      pop_word = '0;
      for (int v = 0; v < `IPC_NUM_VCS; v++)
         if (front.pop_ivc[v])
            pop_word = front.front_ivc[v];
   end

   assign pop_head = |(front.pop_ivc & flit_head_ivc);

   // ------------------------------
   // next hop, wraps modulo 4
   // ------------------------------

   always_comb
   begin
      next_y = router_address[0 +: `IPC_DIM_ADDR_WIDTH];
      next_x = router_address[`IPC_DIM_ADDR_WIDTH +: `IPC_DIM_ADDR_WIDTH];
      case (pop_word.hdr.lar_port)
         `IPC_PORT_XM: next_x = next_x - 1'b1;
         `IPC_PORT_XP: next_x = next_x + 1'b1;
         `IPC_PORT_YM: next_y = next_y - 1'b1;
         `IPC_PORT_YP: next_y = next_y + 1'b1;
         default:      ;
      endcase
   end

   // x first, then y
   always_comb
   begin
      if (pop_word.hdr.dest_x < next_x)
         next_port = `IPC_PORT_XM;
      else if (pop_word.hdr.dest_x > next_x)
         next_port = `IPC_PORT_XP;
      else if (pop_word.hdr.dest_y < next_y)
         next_port = `IPC_PORT_YM;
      else if (pop_word.hdr.dest_y > next_y)
         next_port = `IPC_PORT_YP;
      else
         next_port = `IPC_PORT_NODE;
   end

   always_comb
   begin
      out_word = pop_word;
      if (pop_head)
         out_word.hdr.lar_port = next_port;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         flit_data_out <= '0;
      else if (|front.pop_ivc)
         flit_data_out <= out_word.raw;
   end

endmodule

`default_nettype wire

//--- source/ipc_port_status.sv
// registers outgoing credits and the error flags of the port
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_port_status (
   input  wire                             clk,
   input  wire                             reset,
   input  wire [0:`IPC_NUM_VCS-1]          pop_ivc,
   input  wire [0:2*`IPC_NUM_VCS-1]        vc_errors,
   input  wire [0:2*`IPC_NUM_VCS-1]        buffer_errors,
   output logic [0:`IPC_FLOW_CTRL_WIDTH-1] flow_ctrl_out,
   output logic                            error
);

   logic [0:`IPC_VC_IDX_WIDTH-1] pop_vc;
   logic [0:4*`IPC_NUM_VCS-1]    errors_q;

   // encode the popped VC for the credit
   always_comb
   begin
      pop_vc = '0;
      for (int v = 0; v < `IPC_NUM_VCS; v++)
         if (pop_ivc[v])
            pop_vc = `IPC_VC_IDX_WIDTH'(v);
   end

   // one-cycle credit pulse, errors are not held
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         flow_ctrl_out <= '0;
         errors_q      <= '0;
      end
      else
      begin
         flow_ctrl_out <= {|pop_ivc, pop_vc};
         errors_q      <= {vc_errors, buffer_errors};
      end
   end

   assign error = |errors_q;

endmodule

`default_nettype wire

//--- source/ipc_input_port.sv
// input port controller of one mesh router port, top level with plain ports
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_input_port (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire [0:`IPC_ROUTER_ADDR_WIDTH-1]     router_address,
   input  wire [0:`IPC_CHANNEL_WIDTH-1]         channel_in,
   output wire [0:`IPC_NUM_VCS*`IPC_NUM_PORTS-1] route_out_ivc_op,
   output wire [0:`IPC_NUM_VCS-1]               flit_valid_out_ivc,
   output wire [0:`IPC_NUM_VCS-1]               flit_last_out_ivc,
   output wire [0:`IPC_NUM_VCS-1]               flit_head_out_ivc,
   output wire [0:`IPC_NUM_VCS-1]               flit_tail_out_ivc,
   output wire [0:`IPC_FLIT_DATA_WIDTH-1]       flit_data_out,
   input  wire [0:`IPC_NUM_VCS-1]               flit_sel_in_ivc,
   input  wire                                  flit_sent_in,
   output wire [0:`IPC_FLOW_CTRL_WIDTH-1]       flow_ctrl_out,
   output wire                                  error
);

   ipc_push_if  push_bus ();
   ipc_front_if front_bus ();

   wire [0:`IPC_NUM_VCS-1]   overflow_ivc;
   wire [0:`IPC_NUM_VCS-1]   underflow_ivc;
   // flit-type and invalid-port error per VC
   wire [0:2*`IPC_NUM_VCS-1] vc_errors;

   ipc_channel_input i_chi (
      .clk        (clk),
      .reset      (reset),
      .channel_in (channel_in),
      .push       (push_bus.source)
   );

   ipc_flit_buffer i_fb (
      .clk             (clk),
      .reset           (reset),
      .push            (push_bus.sink),
      .flit_sent_in    (flit_sent_in),
      .flit_sel_in_ivc (flit_sel_in_ivc),
      .front           (front_bus.buffer),
      .overflow_ivc    (overflow_ivc),
      .underflow_ivc   (underflow_ivc)
   );

   // ------------------------------
   // one controller per VC
   // ------------------------------

   for (genvar v = 0; v < `IPC_NUM_VCS; v++)
   begin : g_ivc
      ipc_vc_ctrl #(
         .vc_id (v)
      ) i_vcc (
         .clk                (clk),
         .reset              (reset),
         .push               (push_bus.sink),
         .front              (front_bus.reader),
         .flit_valid_out     (flit_valid_out_ivc[v]),
         .flit_last_out      (flit_last_out_ivc[v]),
         .flit_head_out      (flit_head_out_ivc[v]),
         .flit_tail_out      (flit_tail_out_ivc[v]),
         .route_out_op       (route_out_ivc_op[v*`IPC_NUM_PORTS +: `IPC_NUM_PORTS]),
         .error_flit_type    (vc_errors[2*v]),
         .error_invalid_port (vc_errors[2*v+1])
      );
   end

   ipc_lookahead_update i_lau (
      .clk            (clk),
      .reset          (reset),
      .router_address (router_address),
      .front          (front_bus.reader),
      .flit_head_ivc  (flit_head_out_ivc),
      .flit_data_out  (flit_data_out)
   );

   ipc_port_status i_ps (
      .clk           (clk),
      .reset         (reset),
      .pop_ivc       (front_bus.pop_ivc),
      .vc_errors     (vc_errors),
      .buffer_errors ({overflow_ivc, underflow_ivc}),
      .flow_ctrl_out (flow_ctrl_out),
      .error         (error)
   );

endmodule

`default_nettype wire

//--- bench/ipc_tb.sv
// self-checking testbench that replays bench/ipc_stim.txt against the input port controller
`timescale 1ns/1ps
`default_nettype none

`include "ipc_defs.svh"

module ipc_tb
   import ipc_pkg::*;
();

   localparam int max_lines   = 256;
   localparam int route_width = `IPC_NUM_VCS * `IPC_NUM_PORTS;

   logic                              clk;
   logic                              reset;
   logic [0:`IPC_ROUTER_ADDR_WIDTH-1] router_address;
   logic [0:`IPC_CHANNEL_WIDTH-1]     channel_in;
   logic [0:route_width-1]            route_out_ivc_op;
   logic [0:`IPC_NUM_VCS-1]           flit_valid_out_ivc;
   logic [0:`IPC_NUM_VCS-1]           flit_last_out_ivc;
   logic [0:`IPC_NUM_VCS-1]           flit_head_out_ivc;
   logic [0:`IPC_NUM_VCS-1]           flit_tail_out_ivc;
   logic [0:`IPC_FLIT_DATA_WIDTH-1]   flit_data_out;
   logic [0:`IPC_NUM_VCS-1]           flit_sel_in_ivc;
   logic                              flit_sent_in;
   logic [0:`IPC_FLOW_CTRL_WIDTH-1]   flow_ctrl_out;
   logic                              error;

   // ------------------------------
   // stimulus table with one entry per cycle
   // ------------------------------

   logic [0:`IPC_CHANNEL_WIDTH-1]   stim_channel [0:max_lines-1];
   logic [0:`IPC_NUM_VCS-1]         stim_sel [0:max_lines-1];
   logic                            stim_sent [0:max_lines-1];
   logic [0:`IPC_NUM_VCS-1]         exp_valid [0:max_lines-1];
   logic [0:`IPC_NUM_VCS-1]         exp_head [0:max_lines-1];
   logic [0:`IPC_NUM_VCS-1]         exp_tail [0:max_lines-1];
   logic [0:`IPC_NUM_VCS-1]         exp_last [0:max_lines-1];
   logic [0:route_width-1]          exp_route [0:max_lines-1];
   flit_word_u                      exp_data [0:max_lines-1];
   logic [0:`IPC_FLOW_CTRL_WIDTH-1] exp_credit [0:max_lines-1];
   logic                            exp_error [0:max_lines-1];

   int line_count;
   int cur_line;
   int cycle_limit;
   int cycle_count = 0;

   ipc_input_port i_dut (
      .clk                (clk),
      .reset              (reset),
      .router_address     (router_address),
      .channel_in         (channel_in),
      .route_out_ivc_op   (route_out_ivc_op),
      .flit_valid_out_ivc (flit_valid_out_ivc),
      .flit_last_out_ivc  (flit_last_out_ivc),
      .flit_head_out_ivc  (flit_head_out_ivc),
      .flit_tail_out_ivc  (flit_tail_out_ivc),
      .flit_data_out      (flit_data_out),
      .flit_sel_in_ivc    (flit_sel_in_ivc),
      .flit_sent_in       (flit_sent_in),
      .flow_ctrl_out      (flow_ctrl_out),
      .error              (error)
   );

   always #50 clk = ~clk;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_word(input string name, input flit_word_u got, input flit_word_u exp);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s at stim entry %0d: got 0x%h, expected 0x%h",
            name, cur_line, got.raw, exp.raw));
   endtask

   task automatic check_mask(input string name, input logic [0:route_width-1] got,
                             input logic [0:route_width-1] exp);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s at stim entry %0d: got 0x%h, expected 0x%h",
            name, cur_line, got, exp));
   endtask

   task automatic check_credit(input string name, input logic [0:`IPC_FLOW_CTRL_WIDTH-1] got,
                               input logic [0:`IPC_FLOW_CTRL_WIDTH-1] exp);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s at stim entry %0d: got 0x%h, expected 0x%h",
            name, cur_line, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s at stim entry %0d: got 0x%h, expected 0x%h",
            name, cur_line, got, exp));
   endtask

   // stim columns are valid vc head tail data sel sent and then the expected outputs
   task automatic read_stim();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f [0:13];
      fd = $fopen("bench/ipc_stim.txt", "r");
      if (fd == 0)
         stop_with_failure("could not open the stimulus file bench/ipc_stim.txt");
      line_count = 0;
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line.substr(0, 0) == "#")
            continue;
         if (line_count >= max_lines)
            stop_with_failure("the stimulus file holds more entries than the table");
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
         if (n != 14)
            stop_with_failure($sformatf("stimulus entry %0d does not have 14 columns",
               line_count));
         stim_channel[line_count] = {f[0][0], f[1][`IPC_VC_IDX_WIDTH-1:0], f[2][0], f[3][0], f[4]};
         stim_sel[line_count]     = f[5][`IPC_NUM_VCS-1:0];
         stim_sent[line_count]    = f[6][0];
         exp_valid[line_count]    = f[7][`IPC_NUM_VCS-1:0];
         exp_head[line_count]     = f[8][`IPC_NUM_VCS-1:0];
         exp_tail[line_count]     = f[9][`IPC_NUM_VCS-1:0];
         exp_last[line_count]     = f[10][`IPC_NUM_VCS-1:0];
         exp_route[line_count]    = f[11][route_width-1:0];
         exp_data[line_count]     = f[12];
         exp_credit[line_count]   = f[13][`IPC_FLOW_CTRL_WIDTH-1:0];
         exp_error[line_count]    = f[0][4];
         line_count++;
      end
      $fclose(fd);
   endtask

   task automatic check_line(input int i);
      check_mask("route_out_ivc_op", route_out_ivc_op, exp_route[i]);
      check_word("flit_data_out", flit_data_out, exp_data[i]);
      check_credit("flow_ctrl_out", flow_ctrl_out, exp_credit[i]);
      check_bit("error", error, exp_error[i]);
      for (int v = 0; v < `IPC_NUM_VCS; v++)
      begin
         check_bit($sformatf("flit_valid_out_ivc[%0d]", v),
            flit_valid_out_ivc[v], exp_valid[i][v]);
         check_bit($sformatf("flit_head_out_ivc[%0d]", v),
            flit_head_out_ivc[v], exp_head[i][v]);
         check_bit($sformatf("flit_last_out_ivc[%0d]", v),
            flit_last_out_ivc[v], exp_last[i][v]);
         // tail bit of an empty partition is whatever the slot last held
         if (exp_valid[i][v])
            check_bit($sformatf("flit_tail_out_ivc[%0d]", v),
               flit_tail_out_ivc[v], exp_tail[i][v]);
      end
   endtask

   // ------------------------------
   // run limit
   // ------------------------------

   always @(posedge clk)
   begin
      if (!reset)
      begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= cycle_limit)
            stop_with_failure($sformatf("timeout, run still going after %0d cycles",
               cycle_count));
      end
   end

   initial
   begin
      clk             = 1'b0;
      reset           = 1'b1;
      // router at x=1 and y=2 with y in the upper half
      router_address  = {2'd2, 2'd1};
      channel_in      = '0;
      flit_sel_in_ivc = '0;
      flit_sent_in    = 1'b0;
      cur_line        = 0;
      read_stim();
      cycle_limit = line_count + 20;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      // outputs checked at the falling edge reflect the inputs of entry i-1
      for (int i = 0; i < line_count; i++)
      begin
         @(posedge clk);
         channel_in      <= stim_channel[i];
         flit_sel_in_ivc <= stim_sel[i];
         flit_sent_in    <= stim_sent[i];
         @(negedge clk);
         cur_line = i;
         check_line(i);
      end
      if (line_count > 0)
      begin
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
         stop_with_failure("the stimulus file holds no entries");
   end

endmodule

`default_nettype wire

//--- bench/ipc_stim.txt
# one entry per cycle, hex: cv vc head tail data sel sent | valid head tail last route data_out credit
# cv carries the expected error in bit 4; masks put VC0 first, route is VC0 ports 0-4 then VC1 ports 0-4
00 0 0 0 00000000 0 0 0 3 0 0 000 00000000 0
01 0 1 1 440000A5 0 0 0 3 0 0 000 00000000 0
01 1 1 1 9A001234 0 0 0 3 0 0 000 00000000 0
00 0 0 0 00000000 2 1 2 3 2 2 080 00000000 0
00 0 0 0 00000000 1 1 1 3 1 1 001 640000A5 2
01 0 1 0 38000077 0 0 0 3 0 0 000 1A001234 3
01 0 0 0 11111111 0 0 0 3 0 0 000 1A001234 0
01 0 0 0 22222222 0 0 2 3 0 2 100 1A001234 0
01 0 0 1 33333333 0 0 2 3 0 0 100 1A001234 0
00 0 0 0 00000000 0 0 2 3 0 0 100 1A001234 0
00 0 0 0 00000000 2 1 2 3 0 0 100 1A001234 0
00 0 0 0 00000000 2 1 2 1 0 0 100 98000077 2
00 0 0 0 00000000 2 1 2 1 0 0 100 11111111 2
00 0 0 0 00000000 2 1 2 1 2 2 100 22222222 2
00 0 0 0 00000000 0 0 0 3 0 0 000 33333333 2
01 0 1 0 6A0000C0 0 0 0 3 0 0 000 33333333 0
01 1 1 0 660000D0 0 0 0 3 0 0 000 33333333 0
01 0 0 0 C1C1C1C1 0 0 2 3 0 2 040 33333333 0
01 1 0 0 D1D1D1D1 0 0 3 3 0 3 042 33333333 0
01 0 0 0 C2C2C2C2 0 0 3 3 0 1 042 33333333 0
01 1 0 0 D2D2D2D2 0 0 3 3 0 0 042 33333333 0
01 0 0 1 C3C3C3C3 0 0 3 3 0 0 042 33333333 0
01 1 0 1 D3D3D3D3 0 0 3 3 0 0 042 33333333 0
01 0 1 1 EEEEEEEE 0 0 3 3 0 0 042 33333333 0
00 0 0 0 00000000 2 1 3 3 0 0 042 33333333 0
10 0 0 0 00000000 1 1 3 1 0 0 042 0A0000C0 2
00 0 0 0 00000000 2 1 3 0 0 0 042 460000D0 3
00 0 0 0 00000000 1 1 3 0 0 0 042 C1C1C1C1 2
00 0 0 0 00000000 2 1 3 0 0 0 042 D1D1D1D1 3
00 0 0 0 00000000 1 1 3 0 2 2 042 C2C2C2C2 2
00 0 0 0 00000000 2 1 3 0 3 3 042 D2D2D2D2 3
00 0 0 0 00000000 1 1 1 2 1 1 002 C3C3C3C3 2
00 0 0 0 00000000 1 1 0 3 0 0 000 D3D3D3D3 3
11 1 0 1 0000BEEF 0 0 0 3 0 0 000 D3D3D3D3 0
01 0 1 1 CC000005 0 0 0 3 0 0 000 D3D3D3D3 0
10 0 0 0 00000000 0 0 1 3 1 1 010 D3D3D3D3 0
00 0 0 0 00000000 0 0 3 3 3 3 010 D3D3D3D3 0
10 0 0 0 00000000 2 1 3 3 3 3 010 D3D3D3D3 0
10 0 0 0 00000000 0 0 1 3 1 1 010 4C000005 2
00 0 0 0 00000000 0 0 1 3 1 1 010 4C000005 0

//--- flist.f
+incdir+include
source/ipc_pkg.sv
source/ipc_push_if.sv
source/ipc_front_if.sv
source/ipc_channel_input.sv
source/ipc_flit_buffer.sv
source/ipc_vc_ctrl.sv
source/ipc_lookahead_update.sv
source/ipc_port_status.sv
source/ipc_input_port.sv
bench/ipc_tb.sv

//--- Bender.yml
package:
  name: ipc_input_port

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/ipc_pkg.sv
      - source/ipc_push_if.sv
      - source/ipc_front_if.sv
      - source/ipc_channel_input.sv
      - source/ipc_flit_buffer.sv
      - source/ipc_vc_ctrl.sv
      - source/ipc_lookahead_update.sv
      - source/ipc_port_status.sv
      - source/ipc_input_port.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ipc_tb.sv
